// File: hw/eq_pkg.sv
/*
  Shared types and constants of the scope equalization filter.
  Holds the coefficient widths, the sample widths between the stages,
  the packed coefficient configuration and the fixed-point shift amounts.
  Modules import it inside their body and use scoped names in the port list.
*/

package eq_pkg;

  ////////////////////////////////////////////////////////////
  // coefficients
  ////////////////////////////////////////////////////////////

  // lag IIR coefficient
  typedef logic signed [17:0] coef_aa_t;
  // FIR coefficient
  typedef logic signed [24:0] coef_bb_t;
  // output gain
  typedef logic signed [24:0] coef_kk_t;
  // pole IIR coefficient
  typedef logic signed [24:0] coef_pp_t;

  // full coefficient set, 93 bits
  // kept static while samples are flowing
  typedef struct packed {
    coef_aa_t aa;
    coef_bb_t bb;
    coef_kk_t kk;
    coef_pp_t pp;
  } eq_cfg_t;

  ////////////////////////////////////////////////////////////
  // intermediate samples
  ////////////////////////////////////////////////////////////

  // FIR and lag IIR output
  typedef logic signed [22:0] fir_dat_t;
  // pole IIR output
  typedef logic signed [14:0] pole_dat_t;

  ////////////////////////////////////////////////////////////
  // fixed-point scaling
  ////////////////////////////////////////////////////////////

  // fraction bits dropped after each FIR step
  localparam int fir_frac = 10;
  // lag IIR fraction width
  localparam int lag_frac = 25;
  // pole IIR input attenuation
  localparam int pole_in_shift = 8;
  // pole IIR feedback fraction
  localparam int pole_fb_shift = 16;
  // gain fraction
  localparam int gain_shift = 24;

endpackage

// File: hw/eq_fir.sv
/*
  Two-tap FIR at the head of the equalization chain.
  y = ((2^28 + bb) * x[n] - 2^28 * x[n-1]) / 2^20, in two pipeline steps.
  A multiply register holds both taps, a sum register holds the result.
  Two cycles from an accepted input to fir_valid, one sample per cycle.
*/

`timescale 1ns/1ps

module eq_fir #(
  parameter int unsigned dwi = 14
) (
  input  logic                  sti,
  input  logic                  reset,
  input  eq_pkg::coef_bb_t      bb,
  input  logic                  adc_valid,
  input  logic signed [dwi-1:0] adc_data,
  output logic                  adc_ready,
  output logic                  fir_valid,
  output eq_pkg::fir_dat_t      fir_data,
  input  logic                  fir_ready
);
  import eq_pkg::*;

  // unity tap weight is 2^28
  localparam int unity_exp = 18 + fir_frac;

  // tap coefficient, one bit of headroom over 2^28 + bb
  typedef logic signed [29:0] tap_coef_t;
  typedef logic signed [dwi+29:0] tap_mul_t;
  typedef logic signed [dwi+30:0] tap_sum_t;

  logic signed [dwi-1:0] xp;
  tap_coef_t coef0;
  tap_coef_t coef1;
  tap_mul_t prod0;
  tap_mul_t prod1;
  tap_mul_t m0;
  tap_mul_t m1;
  logic mul_valid;
  logic mul_ready;
  tap_sum_t sum_full;
  tap_sum_t sum_shr;

  ////////////////////////////////////////////////////////////
  // multiply step
  ////////////////////////////////////////////////////////////

  assign coef0 = (tap_coef_t'(1) <<< unity_exp) + bb;
  assign coef1 = -(tap_coef_t'(1) <<< unity_exp);

  // full precision products
  assign prod0 = adc_data * coef0;
  assign prod1 = xp * coef1;

  // xp follows the accepted samples only
  always_ff @(posedge sti) begin
    if (reset) begin
      xp <= '0;
      m0 <= '0;
      m1 <= '0;
    end else if (adc_valid && adc_ready) begin
      xp <= adc_data;
      m0 <= prod0 >>> fir_frac;
      m1 <= prod1 >>> fir_frac;
    end
  end

  ////////////////////////////////////////////////////////////
  // sum step
  ////////////////////////////////////////////////////////////

  assign sum_full = m0 + m1;
  assign sum_shr  = sum_full >>> fir_frac;

  // low 23 bits kept
  always_ff @(posedge sti) begin
    if (reset) begin
      fir_data <= '0;
    end else if (mul_valid && mul_ready) begin
      fir_data <= fir_dat_t'(sum_shr);
    end
  end

  // handshake of both pipeline registers
  always_ff @(posedge sti) begin
    if (reset) begin
      mul_valid <= 1'b0;
      fir_valid <= 1'b0;
    end else begin
      if (adc_ready) mul_valid <= adc_valid;
      if (mul_ready) fir_valid <= mul_valid;
    end
  end

  // a register accepts when drained downstream or empty
  assign mul_ready = fir_ready | ~fir_valid;
  assign adc_ready = mul_ready | ~mul_valid;

endmodule

// File: hw/eq_iir_lag.sv
/*
  First-order lag IIR, second stage of the equalization chain.
  y[n] = (2^25 * x[n] + (2^25 - aa) * y[n-1]) / 2^25
  The output register doubles as the feedback history.
  One cycle from an accepted input to lag_valid.
*/

`timescale 1ns/1ps

module eq_iir_lag (
  input  logic             sti,
  input  logic             reset,
  input  eq_pkg::coef_aa_t aa,
  input  logic             fir_valid,
  input  eq_pkg::fir_dat_t fir_data,
  output logic             fir_ready,
  output logic             lag_valid,
  output eq_pkg::fir_dat_t lag_data,
  input  logic             lag_ready
);
  import eq_pkg::*;

  // feedback weight 2^25 - aa needs 27 bits
  typedef logic signed [26:0] lag_coef_t;
  // 23 x 27 product plus the scaled input
  typedef logic signed [51:0] lag_acc_t;

  lag_coef_t fb_coef;
  lag_acc_t acc;
  lag_acc_t acc_shr;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  assign fb_coef = (lag_coef_t'(1) <<< lag_frac) - aa;

  // lag_data is y[n-1]
  assign acc     = (lag_acc_t'(fir_data) <<< lag_frac) + lag_data * fb_coef;
  assign acc_shr = acc >>> lag_frac;

  always_ff @(posedge sti) begin
    if (reset) begin
      lag_data <= '0;
    end else if (fir_valid && fir_ready) begin
      lag_data <= fir_dat_t'(acc_shr);
    end
  end

  // handshake
  always_ff @(posedge sti) begin
    if (reset) begin
      lag_valid <= 1'b0;
    end else if (fir_ready) begin
      lag_valid <= fir_valid;
    end
  end

  assign fir_ready = lag_ready | ~lag_valid;

endmodule

// File: hw/eq_iir_pole.sv
/*
  First-order pole IIR, third stage of the equalization chain.
  y[n] = x[n] / 2^8 + pp * y[n-1] / 2^16, kept to 15 bits.
  The output register is the feedback history.
  One cycle from an accepted input to pole_valid.
*/

`timescale 1ns/1ps

module eq_iir_pole (
  input  logic              sti,
  input  logic              reset,
  input  eq_pkg::coef_pp_t  pp,
  input  logic              lag_valid,
  input  eq_pkg::fir_dat_t  lag_data,
  output logic              lag_ready,
  output logic              pole_valid,
  output eq_pkg::pole_dat_t pole_data,
  input  logic              pole_ready
);
  import eq_pkg::*;

  // 15 x 25 feedback product
  typedef logic signed [39:0] pole_prod_t;
  // one guard bit for the sum
  typedef logic signed [40:0] pole_sum_t;

  pole_prod_t fb_prod;
  pole_sum_t sum;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  // pole_data is y[n-1]
  assign fb_prod = pole_data * pp;

  // both terms sign extended before the shifts
  assign sum = (pole_sum_t'(lag_data) >>> pole_in_shift) + (fb_prod >>> pole_fb_shift);

  always_ff @(posedge sti) begin
    if (reset) begin
      pole_data <= '0;
    end else if (lag_valid && lag_ready) begin
      pole_data <= pole_dat_t'(sum);
    end
  end

  // handshake
  always_ff @(posedge sti) begin
    if (reset) begin
      pole_valid <= 1'b0;
    end else if (lag_ready) begin
      pole_valid <= lag_valid;
    end
  end

  assign lag_ready = pole_ready | ~pole_valid;

endmodule

// File: hw/eq_scale_sat.sv
/*
  Output gain and saturation, last stage of the equalization chain.
  y = clamp((x * kk) / 2^24) to the signed dwo range.
  Values above the maximum or below the minimum stick to that bound.
  One cycle from an accepted input to flt_valid.
*/

`timescale 1ns/1ps

module eq_scale_sat #(
  parameter int unsigned dwo = 14
) (
  input  logic                  sti,
  input  logic                  reset,
  input  eq_pkg::coef_kk_t      kk,
  input  logic                  pole_valid,
  input  eq_pkg::pole_dat_t     pole_data,
  output logic                  pole_ready,
  output logic                  flt_valid,
  output logic signed [dwo-1:0] flt_data,
  input  logic                  flt_ready
);
  import eq_pkg::*;

  // 15 x 25 product
  typedef logic signed [39:0] gain_t;

  // bounds of the output range
  localparam gain_t sat_max = (gain_t'(1) <<< (dwo - 1)) - 1;
  localparam gain_t sat_min = -(gain_t'(1) <<< (dwo - 1));

  gain_t prod;
  gain_t scaled;
  gain_t clamped;

  ////////////////////////////////////////////////////////////
  // gain and clamp
  ////////////////////////////////////////////////////////////

  assign prod   = pole_data * kk;
  assign scaled = prod >>> gain_shift;

  // two-sided clamp
  always_comb begin
    if (scaled > sat_max) begin
      clamped = sat_max;
    end else if (scaled < sat_min) begin
      clamped = sat_min;
    end else begin
      clamped = scaled;
    end
  end

  always_ff @(posedge sti) begin
    if (reset) begin
      flt_data <= '0;
    end else if (pole_valid && pole_ready) begin
      flt_data <= clamped[dwo-1:0];
    end
  end

  // handshake
  always_ff @(posedge sti) begin
    if (reset) begin
      flt_valid <= 1'b0;
    end else if (pole_ready) begin
      flt_valid <= pole_valid;
    end
  end

  assign pole_ready = flt_ready | ~flt_valid;

endmodule

// File: hw/scope_filter.sv
/*
  Equalization filter between the fast ADC and the acquisition path.
  Chains FIR, lag IIR, pole IIR and gain with saturation.
  Every link uses valid/ready, a beat moves when both are high.
  Five cycles of latency with flt_ready high, one sample per cycle.
  cfg must stay static while samples are in flight.
*/

`timescale 1ns/1ps

module scope_filter #(
  parameter int unsigned dwi = 14,
  parameter int unsigned dwo = 14
) (
  input  logic                  sti,
  input  logic                  reset,
  input  eq_pkg::eq_cfg_t       cfg,
  input  logic                  adc_valid,
  input  logic signed [dwi-1:0] adc_data,
  output logic                  adc_ready,
  output logic                  flt_valid,
  output logic signed [dwo-1:0] flt_data,
  input  logic                  flt_ready
);
  import eq_pkg::*;

  ////////////////////////////////////////////////////////////
  // links between the stages
  ////////////////////////////////////////////////////////////

  // FIR to lag IIR, s23
  logic      fir_valid;
  fir_dat_t  fir_data;
  logic      fir_ready;

  // lag IIR to pole IIR, s23
  logic      lag_valid;
  fir_dat_t  lag_data;
  logic      lag_ready;

  // pole IIR to gain, s15
  logic      pole_valid;
  pole_dat_t pole_data;
  logic      pole_ready;

  ////////////////////////////////////////////////////////////
  // stage chain
  ////////////////////////////////////////////////////////////

  // 2 cycles
  eq_fir #(
    .dwi (dwi)
  ) u_fir (
    .sti       (sti),
    .reset     (reset),
    .bb        (cfg.bb),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .adc_ready (adc_ready),
    .fir_valid (fir_valid),
    .fir_data  (fir_data),
    .fir_ready (fir_ready)
  );

  eq_iir_lag u_lag (
    .sti       (sti),
    .reset     (reset),
    .aa        (cfg.aa),
    .fir_valid (fir_valid),
    .fir_data  (fir_data),
    .fir_ready (fir_ready),
    .lag_valid (lag_valid),
    .lag_data  (lag_data),
    .lag_ready (lag_ready)
  );

  eq_iir_pole u_pole (
    .sti        (sti),
    .reset      (reset),
    .pp         (cfg.pp),
    .lag_valid  (lag_valid),
    .lag_data   (lag_data),
    .lag_ready  (lag_ready),
    .pole_valid (pole_valid),
    .pole_data  (pole_data),
    .pole_ready (pole_ready)
  );

  // gain and clamp to dwo
  eq_scale_sat #(
    .dwo (dwo)
  ) u_sat (
    .sti        (sti),
    .reset      (reset),
    .kk         (cfg.kk),
    .pole_valid (pole_valid),
    .pole_data  (pole_data),
    .pole_ready (pole_ready),
    .flt_valid  (flt_valid),
    .flt_data   (flt_data),
    .flt_ready  (flt_ready)
  );

endmodule

// File: testbench/scope_filter_tb.sv
/*
  Testbench of the scope equalization filter.
  Drives samples and output back-pressure on the falling edge, predicts every
  output with a bit-exact model of the four stages, and compares each output
  transfer against the model queue. Prints one line per test and a summary.
*/

`timescale 1ns/1ps

module scope_filter_tb;
  import eq_pkg::*;

  localparam int dwi = 14;
  localparam int dwo = 14;
  localparam int n_stream = 200;
  localparam int n_sat = 24;
  localparam int n_hist = 40;
  // cycle budget of all tests, the watchdog allows twice that
  localparam int stim_cycles = 5 * 16 + 20 + n_stream + 5 * n_stream + 2 * n_sat + n_hist;
  localparam int cycle_limit = 2 * stim_cycles + 100;

  localparam logic signed [dwi-1:0] in_max = {1'b0, {(dwi-1){1'b1}}};
  localparam logic signed [dwi-1:0] in_min = {1'b1, {(dwi-1){1'b0}}};
  localparam logic signed [dwo-1:0] out_max = {1'b0, {(dwo-1){1'b1}}};
  localparam logic signed [dwo-1:0] out_min = {1'b1, {(dwo-1){1'b0}}};

  logic sti;
  logic reset;
  eq_cfg_t cfg;
  logic adc_valid;
  logic signed [dwi-1:0] adc_data;
  logic adc_ready;
  logic flt_valid;
  logic signed [dwo-1:0] flt_data;
  logic flt_ready;

  // expected outputs in order
  logic signed [dwo-1:0] exp_q[$];
  logic signed [dwi-1:0] stream [0:n_stream-1];
  // model history
  longint xp_m;
  longint lag_m;
  longint pole_m;

  logic [31:0] seed_data;
  logic [31:0] seed_rdy;
  bit ready_rand;
  string cur_test;
  int err_cnt;
  int test_err_base;
  int tests_passed;
  int tests_failed;
  int acc_cnt;
  int out_cnt;
  int hit_max;
  int hit_min;
  int cycles;

  scope_filter #(
    .dwi (dwi),
    .dwo (dwo)
  ) uut (
    .sti       (sti),
    .reset     (reset),
    .cfg       (cfg),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .adc_ready (adc_ready),
    .flt_valid (flt_valid),
    .flt_data  (flt_data),
    .flt_ready (flt_ready)
  );

  // 4 ns period
  always #2 sti = ~sti;

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] draw();
    seed_data = lcg_next(seed_data);
    return seed_data;
  endfunction

  // keep the low w bits, sign extended
  function automatic longint sext(input longint v, input int w);
    return (v <<< (64 - w)) >>> (64 - w);
  endfunction

  // one accepted sample through FIR, lag, pole and gain
  function automatic logic signed [dwo-1:0] model_step(input longint x);
    longint m0;
    longint m1;
    longint f;
    longint l;
    longint p;
    longint g;
    m0 = (x * ((longint'(1) <<< 28) + longint'($signed(cfg.bb)))) >>> 10;
    m1 = (xp_m * -(longint'(1) <<< 28)) >>> 10;
    f = sext((m0 + m1) >>> 10, 23);
    xp_m = x;
    l = (f <<< 25) + lag_m * ((longint'(1) <<< 25) - longint'($signed(cfg.aa)));
    l = sext(l >>> 25, 23);
    lag_m = l;
    p = sext((l >>> 8) + ((pole_m * longint'($signed(cfg.pp))) >>> 16), 15);
    pole_m = p;
    g = (p * longint'($signed(cfg.kk))) >>> 24;
    if (g > longint'(out_max)) return out_max;
    else if (g < longint'(out_min)) return out_min;
    return g[dwo-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic check_sample(input string name, input logic signed [dwo-1:0] exp,
                              input logic signed [dwo-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      err_cnt++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // accepted inputs feed the model, output transfers pop it
  always @(posedge sti) begin
    if (!reset) begin
      if (adc_valid && adc_ready) begin
        exp_q.push_back(model_step(adc_data));
        acc_cnt++;
      end
      if (flt_valid && flt_ready) begin
        out_cnt++;
        if (flt_data == out_max) hit_max++;
        if (flt_data == out_min) hit_min++;
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("test %s: output %0d came out with no sample pending", cur_test, flt_data);
        end else begin
          check_sample(cur_test, exp_q.pop_front(), flt_data);
        end
      end
    end
  end

  // downstream back-pressure, own seed so it does not disturb the data sequence
  always @(negedge sti) begin
    if (ready_rand) begin
      seed_rdy = lcg_next(seed_rdy);
      flt_ready = seed_rdy[20];
    end else begin
      flt_ready = 1'b1;
    end
  end

  // watchdog
  always @(posedge sti) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run still busy after %0d cycles in test %s", cycles, cur_test);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks, all start and end on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic apply_reset(input bit check);
    reset = 1'b1;
    adc_valid = 1'b0;
    // in-flight samples are flushed, model history too
    exp_q.delete();
    xp_m = 0;
    lag_m = 0;
    pole_m = 0;
    repeat (16) begin
      @(negedge sti);
      if (check) begin
        check_level("reset flt_valid", 1'b0, flt_valid);
        check_level("reset adc_ready", 1'b1, adc_ready);
      end
    end
    reset = 1'b0;
  endtask

  // holds the sample until the edge that accepts it
  task automatic send_sample(input logic signed [dwi-1:0] x);
    adc_valid = 1'b1;
    adc_data = x;
    @(posedge sti);
    while (!adc_ready) @(posedge sti);
    @(negedge sti);
  endtask

  task automatic random_cfg();
    logic [31:0] r;
    r = draw();
    cfg.aa = coef_aa_t'({1'b0, r[30:14]});
    r = draw();
    cfg.bb = coef_bb_t'(r[31:7]);
    r = draw();
    cfg.kk = coef_kk_t'(r[31:7]);
    r = draw();
    // pole kept inside |pp| < 0.5
    cfg.pp = coef_pp_t'($signed(r[31:16]));
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err_base = err_cnt;
    acc_cnt = 0;
    out_cnt = 0;
    hit_max = 0;
    hit_min = 0;
  endtask

  task automatic drain();
    int n;
    adc_valid = 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < 100) begin
      @(negedge sti);
      n++;
    end
  endtask

  task automatic end_test();
    drain();
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("test %s: %0d expected samples never came out", cur_test, exp_q.size());
      exp_q.delete();
    end
    if (err_cnt == test_err_base) begin
      tests_passed++;
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int lat;
    logic [31:0] r;
    sti = 1'b0;
    reset = 1'b1;
    cfg = '0;
    adc_valid = 1'b0;
    adc_data = '0;
    flt_ready = 1'b1;
    seed_data = 32'd42;
    seed_rdy = 32'd42;
    ready_rand = 1'b0;
    err_cnt = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles = 0;

    begin_test("reset_state");
    @(negedge sti);
    apply_reset(1'b1);
    @(negedge sti);
    check_level("after reset flt_valid", 1'b0, flt_valid);
    check_level("after reset adc_ready", 1'b1, adc_ready);
    end_test();

    // single sample
    // the accepting edge is cycle one of the count
    begin_test("latency");
    random_cfg();
    r = draw();
    send_sample(r[31 -: dwi]);
    adc_valid = 1'b0;
    lat = 1;
    while (!flt_valid && lat < 20) begin
      @(negedge sti);
      lat++;
    end
    check_count("latency cycles", 5, lat);
    end_test();

    begin_test("streaming");
    random_cfg();
    for (int i = 0; i < n_stream; i++) begin
      r = draw();
      stream[i] = r[31 -: dwi];
    end
    for (int i = 0; i < n_stream; i++) send_sample(stream[i]);
    end_test();

    // same stream, random gaps and random flt_ready
    begin_test("backpressure");
    ready_rand = 1'b1;
    for (int i = 0; i < n_stream; i++) begin
      send_sample(stream[i]);
      r = draw();
      if (r[31:30] == 2'b00) begin
        adc_valid = 1'b0;
        repeat (1 + r[29:28] % 3) @(negedge sti);
      end
    end
    drain();
    // stray extra outputs would surface here
    repeat (8) @(negedge sti);
    check_count("backpressure output count", acc_cnt, out_cnt);
    ready_rand = 1'b0;
    end_test();

    // near unity gain, pole gain 4/3 pushes past both bounds
    begin_test("saturation");
    apply_reset(1'b0);
    cfg.aa = coef_aa_t'(18'sd131071);
    cfg.bb = '0;
    cfg.pp = coef_pp_t'(25'sd16384);
    cfg.kk = coef_kk_t'(25'sd16777215);
    repeat (n_sat) send_sample(in_max);
    repeat (n_sat) send_sample(in_min);
    drain();
    check_level("saturation reached max", 1'b1, hit_max != 0);
    check_level("saturation reached min", 1'b1, hit_min != 0);
    end_test();

    // reset pulse with samples still in flight
    begin_test("history_clear");
    random_cfg();
    for (int i = 0; i < n_hist; i++) begin
      if (i == n_hist / 2) apply_reset(1'b0);
      r = draw();
      send_sample(r[31 -: dwi]);
    end
    end_test();

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/eq_pkg.sv
hw/eq_fir.sv
hw/eq_iir_lag.sv
hw/eq_iir_pole.sv
hw/eq_scale_sat.sv
hw/scope_filter.sv
testbench/scope_filter_tb.sv
